//--- Bender.yml
package:
  name: ps2_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/ps2_link_pkg.sv
      - source/ps2_host_pkg.sv
      - source/ps2_line_filter.sv
      - source/ps2_port.sv
      - source/ps2_regs.sv
      - source/ps2_ctrl_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/ps2_ctrl_sva.sv
      - tb/ps2_ctrl_tb.sv

//--- build.f
+incdir+source
source/ps2_link_pkg.sv
source/ps2_host_pkg.sv
source/ps2_line_filter.sv
source/ps2_port.sv
source/ps2_regs.sv
source/ps2_ctrl_top.sv
tb/ps2_ctrl_sva.sv
tb/ps2_ctrl_tb.sv

//--- source/ps2_consts.svh
`ifndef PS2_CONSTS_SVH
`define PS2_CONSTS_SVH

// samples of history kept per ps2 line.
`define PS2_FILTER_DEPTH 8

// host holds the clock low until this timeout counter bit sets.
`define PS2_RING_BIT 12

// default width of the inactivity counter.
`define PS2_TIMEOUT_BITS 24

// width of the register address field on the host bus.
`define PS2_REG_ADDR_BITS 2

// control register after reset, irq off and prescale 0.
`define PS2_PRESCALE_RESET 8'd0

`endif

//--- source/ps2_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_ctrl_top #(
	parameter int TIMEOUT_BITS = `PS2_TIMEOUT_BITS
) (
	input  logic                   sysclk,
	input  logic                   reset,
	input  ps2_host_pkg::bus_req_t bus_req,
	output logic [7:0]             rdata,
	output logic                   irq,
	input  logic                   ps2clk,
	input  logic                   ps2dat,
	output logic                   clk_drive_low,
	output logic                   dat_drive_low
);

	logic                       clk_en;
	logic                       oreq;
	logic [7:0]                 obyte;
	ps2_link_pkg::line_sample_t line;
	ps2_link_pkg::port_event_t  evt;
	ps2_link_pkg::port_state_e  state;

	ps2_line_filter filter_i (
		.sysclk (sysclk),
		.reset  (reset),
		.clk_en (clk_en),
		.ps2clk (ps2clk),
		.ps2dat (ps2dat),
		.line   (line)
	);

	ps2_port #(
		.TIMEOUT_BITS (TIMEOUT_BITS)
	) port_i (
		.sysclk        (sysclk),
		.reset         (reset),
		.clk_en        (clk_en),
		.line          (line),
		.oreq          (oreq),
		.obyte         (obyte),
		.evt           (evt),
		.state         (state),
		.clk_drive_low (clk_drive_low),
		.dat_drive_low (dat_drive_low)
	);

	// registers set the enable rate and steer the port.
	ps2_regs regs_i (
		.sysclk (sysclk),
		.reset  (reset),
		.bus    (bus_req),
		.rdata  (rdata),
		.irq    (irq),
		.clk_en (clk_en),
		.oreq   (oreq),
		.obyte  (obyte),
		.evt    (evt),
		.state  (state)
	);

endmodule

`default_nettype wire

//--- source/ps2_host_pkg.sv
`default_nettype none

`include "ps2_consts.svh"

// types seen by the cpu side of the controller.
package ps2_host_pkg;

	typedef enum logic [`PS2_REG_ADDR_BITS-1:0] {
		REG_DATA   = 2'd0,
		REG_STATUS = 2'd1,
		REG_CTRL   = 2'd2
	} reg_addr_e;

	// one bus access, wr and rd are single cycle strobes.
	typedef struct packed {
		logic       wr;
		logic       rd;
		reg_addr_e  addr;
		logic [7:0] wdata;
	} bus_req_t;

	// layout of the status register, bit 0 is rx_valid.
	typedef struct packed {
		logic [1:0]                reserved;
		ps2_link_pkg::port_state_e state;
		logic                      tx_busy;
		logic                      timed_out;
		logic                      overrun;
		logic                      rx_valid;
	} status_t;

endpackage

`default_nettype wire

//--- source/ps2_line_filter.sv
`timescale 1ns/10ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_line_filter (
	input  logic                       sysclk,
	input  logic                       reset,
	input  logic                       clk_en,
	input  logic                       ps2clk,
	input  logic                       ps2dat,
	output ps2_link_pkg::line_sample_t line
);

	// oldest samples that must agree before a level flips.
	localparam int AGREE = 6;

	// index 0 is the clock line, index 1 the data line.
	logic [1:0][`PS2_FILTER_DEPTH-1:0] hist;
	logic [1:0]                        level;
	logic [1:0]                        pins;
	logic                              clk_prev;

	assign pins = {ps2dat, ps2clk};

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			hist     <= '0;
			level    <= '0;
			clk_prev <= 1'b0;
		end else if (clk_en) begin
			clk_prev <= level[0];
			for (int i = 0; i < 2; i++) begin
				hist[i] <= {hist[i][`PS2_FILTER_DEPTH-2:0], pins[i]};
				// hysteresis, a mixed window keeps the old level.
				if (~|hist[i][`PS2_FILTER_DEPTH-1 -: AGREE])
					level[i] <= 1'b0;
				else if (&hist[i][`PS2_FILTER_DEPTH-1 -: AGREE])
					level[i] <= 1'b1;
			end
		end
	end

	assign line.clk_level = level[0];
	assign line.dat_level = level[1];
	assign line.clk_fall  = clk_prev & ~level[0];

endmodule

`default_nettype wire

//--- source/ps2_link_pkg.sv
`default_nettype none

// types shared between the line side blocks.
package ps2_link_pkg;

	// framing engine states.
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_RING = 2'd1,
		ST_SEND = 2'd2,
		ST_RECV = 2'd3
	} port_state_e;

	// filtered lines, filter to port.
	typedef struct packed {
		logic clk_level;
		logic dat_level;
		logic clk_fall;
	} line_sample_t;

	// strobes and received byte, port to registers.
	typedef struct packed {
		logic       istrobe;
		logic       oack;
		logic       timeout;
		logic [7:0] ibyte;
	} port_event_t;

endpackage

`default_nettype wire

//--- source/ps2_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_port #(
	parameter int TIMEOUT_BITS = `PS2_TIMEOUT_BITS
) (
	input  logic                       sysclk,
	input  logic                       reset,
	input  logic                       clk_en,
	input  ps2_link_pkg::line_sample_t line,
	input  logic                       oreq,
	input  logic [7:0]                 obyte,
	output ps2_link_pkg::port_event_t  evt,
	output ps2_link_pkg::port_state_e  state,
	output logic                       clk_drive_low,
	output logic                       dat_drive_low
);

	// start bit is taken on the idle to recv edge, so 10 remain.
	localparam logic [3:0] RECV_BITS = 4'd10;
	localparam logic [3:0] SEND_BITS = 4'd11;

	logic [10:0]             shift_q;
	logic [3:0]              count_q;
	logic [TIMEOUT_BITS-1:0] time_q;
	logic                    req_hold;
	logic                    req;
	logic                    can_load;
	logic                    shift_end;
	logic                    time_up;
	logic                    opar;

	// a request between enables waits for the next one.
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset)
			req_hold <= 1'b0;
		else if (clk_en)
			req_hold <= 1'b0;
		else if (oreq)
			req_hold <= 1'b1;
	end

	assign req       = oreq | req_hold;
	assign can_load  = (state == ps2_link_pkg::ST_IDLE) || (state == ps2_link_pkg::ST_RECV);
	assign shift_end = (count_q == 4'd0);
	assign time_up   = &time_q;

	// odd parity over the outgoing byte.
	assign opar = ~^obyte;

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			state <= ps2_link_pkg::ST_IDLE;
		end else if (clk_en) begin
			if (time_up && !req) begin
				state <= ps2_link_pkg::ST_IDLE;
			end else begin
				case (state)
					ps2_link_pkg::ST_IDLE: begin
						if (req)
							state <= ps2_link_pkg::ST_RING;
						else if (line.clk_fall)
							state <= ps2_link_pkg::ST_RECV;
					end
					ps2_link_pkg::ST_RING: begin
						if (time_q[`PS2_RING_BIT])
							state <= ps2_link_pkg::ST_SEND;
					end
					ps2_link_pkg::ST_SEND: begin
						if (shift_end)
							state <= ps2_link_pkg::ST_IDLE;
					end
					ps2_link_pkg::ST_RECV: begin
						if (req)
							state <= ps2_link_pkg::ST_RING;
						else if (shift_end)
							state <= ps2_link_pkg::ST_IDLE;
					end
					default: state <= ps2_link_pkg::ST_IDLE;
				endcase
			end
		end
	end

	// bit counter, reloaded in idle and while ringing.
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset)
			count_q <= RECV_BITS;
		else if (clk_en) begin
			if (state == ps2_link_pkg::ST_IDLE)
				count_q <= RECV_BITS;
			else if (state == ps2_link_pkg::ST_RING)
				count_q <= SEND_BITS;
			else if (line.clk_fall)
				count_q <= count_q - 4'd1;
		end
	end

	// frame is stop, parity, byte, start with start in bit 0.
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset)
			shift_q <= '0;
		else if (clk_en) begin
			if (req && can_load)
				shift_q <= {1'b1, opar, obyte, 1'b0};
			else if (line.clk_fall && state != ps2_link_pkg::ST_RING)
				shift_q <= {line.dat_level, shift_q[10:1]};
		end
	end

	// inactivity counter, also times the ring phase.
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset)
			time_q <= '0;
		else if (clk_en) begin
			if (line.clk_fall || req)
				time_q <= '0;
			else
				time_q <= time_q + 1'b1;
		end
	end

	// events last a single sysclk, on the enable that ends the frame.
	assign evt.istrobe = clk_en && state == ps2_link_pkg::ST_RECV && shift_end;
	assign evt.oack    = clk_en && state == ps2_link_pkg::ST_SEND && shift_end;
	assign evt.timeout = clk_en && time_up;
	assign evt.ibyte   = shift_q[8:1];

	assign clk_drive_low = (state == ps2_link_pkg::ST_RING);
	assign dat_drive_low = ((state == ps2_link_pkg::ST_RING) ||
		(state == ps2_link_pkg::ST_SEND)) && !shift_q[0];

endmodule

`default_nettype wire

//--- source/ps2_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_regs (
	input  logic                      sysclk,
	input  logic                      reset,
	input  ps2_host_pkg::bus_req_t    bus,
	output logic [7:0]                rdata,
	output logic                      irq,
	output logic                      clk_en,
	output logic                      oreq,
	output logic [7:0]                obyte,
	input  ps2_link_pkg::port_event_t evt,
	input  ps2_link_pkg::port_state_e state
);

	// ctrl is irq_en in bit 7 and prescale below it.
	logic [7:0]            ctrl_q;
	logic [7:0]            ctrl_d;
	logic [6:0]            presc_cnt;
	logic [7:0]            rx_byte;
	ps2_host_pkg::status_t status_q;
	ps2_host_pkg::status_t status_d;
	ps2_host_pkg::status_t status_view;
	logic                  wr_data;
	logic                  wr_status;
	logic                  wr_ctrl;
	logic                  rd_data;
	logic                  tx_accept;

	assign wr_data   = bus.wr && bus.addr == ps2_host_pkg::REG_DATA;
	assign wr_status = bus.wr && bus.addr == ps2_host_pkg::REG_STATUS;
	assign wr_ctrl   = bus.wr && bus.addr == ps2_host_pkg::REG_CTRL;
	assign rd_data   = bus.rd && bus.addr == ps2_host_pkg::REG_DATA;
	assign tx_accept = wr_data && !status_q.tx_busy;

	// down counter, enable on the reload cycle.
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset)
			presc_cnt <= '0;
		else if (presc_cnt == 7'd0)
			presc_cnt <= ctrl_q[6:0];
		else
			presc_cnt <= presc_cnt - 7'd1;
	end

	assign clk_en = (presc_cnt == 7'd0);

	always_ff @(posedge sysclk) begin
		if (tx_accept)
			obyte <= bus.wdata;
		if (evt.istrobe)
			rx_byte <= evt.ibyte;
	end

	// flag updates, setting events win over clears.
	always_comb begin
		status_d          = status_q;
		status_d.reserved = '0;
		status_d.state    = ps2_link_pkg::ST_IDLE;
		if (rd_data)
			status_d.rx_valid = 1'b0;
		if (wr_status && bus.wdata[1])
			status_d.overrun = 1'b0;
		if (wr_status && bus.wdata[2])
			status_d.timed_out = 1'b0;
		if (tx_accept)
			status_d.tx_busy = 1'b1;
		if (evt.oack || evt.timeout)
			status_d.tx_busy = 1'b0;
		// idle line timeouts are not errors.
		if (evt.timeout && (status_q.tx_busy || state != ps2_link_pkg::ST_IDLE))
			status_d.timed_out = 1'b1;
		if (evt.istrobe) begin
			if (status_q.rx_valid && !rd_data)
				status_d.overrun = 1'b1;
			status_d.rx_valid = 1'b1;
		end
	end

	assign ctrl_d = wr_ctrl ? bus.wdata : ctrl_q;

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			status_q <= '0;
			ctrl_q   <= `PS2_PRESCALE_RESET;
			oreq     <= 1'b0;
			irq      <= 1'b0;
		end else begin
			status_q <= status_d;
			ctrl_q   <= ctrl_d;
			oreq     <= tx_accept;
			// next values, so irq never lags a cleared rx_valid.
			irq      <= status_d.rx_valid & ctrl_d[7];
		end
	end

	always_comb begin
		status_view       = status_q;
		status_view.state = state;
	end

	always_comb begin
		case (bus.addr)
			ps2_host_pkg::REG_DATA:   rdata = rx_byte;
			ps2_host_pkg::REG_STATUS: rdata = status_view;
			ps2_host_pkg::REG_CTRL:   rdata = ctrl_q;
			default:                  rdata = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

//--- tb/ps2_ctrl_sva.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_ctrl_sva (
	input logic                      sysclk,
	input logic                      reset,
	input logic                      clk_drive_low,
	input logic                      dat_drive_low,
	input logic                      irq,
	input logic                      rx_valid,
	input logic                      oreq,
	input ps2_link_pkg::port_event_t evt
);

	// read by the testbench at the end of the run.
	int fail_count = 0;

	// pins stay released while the core is held in reset.
	drive_quiet_in_reset: assert property (@(posedge sysclk)
		reset |-> !clk_drive_low && !dat_drive_low)
	else begin
		$error("open-drain enable active during reset");
		fail_count++;
	end

	// receive and send frames never end together.
	events_exclusive: assert property (@(posedge sysclk) disable iff (reset)
		!(evt.istrobe && evt.oack))
	else begin
		$error("istrobe and oack high in the same cycle");
		fail_count++;
	end

	irq_needs_data: assert property (@(posedge sysclk) disable iff (reset)
		irq |-> rx_valid)
	else begin
		$error("irq raised without rx_valid");
		fail_count++;
	end

	oreq_single: assert property (@(posedge sysclk) disable iff (reset)
		oreq |=> !oreq)
	else begin
		$error("oreq held longer than one cycle");
		fail_count++;
	end

endmodule

bind ps2_ctrl_top ps2_ctrl_sva sva_i (
	.sysclk        (sysclk),
	.reset         (reset),
	.clk_drive_low (clk_drive_low),
	.dat_drive_low (dat_drive_low),
	.irq           (irq),
	.rx_valid      (regs_i.status_q.rx_valid),
	.oreq          (oreq),
	.evt           (evt)
);

`default_nettype wire

//--- tb/ps2_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_ctrl_tb;

	localparam int TB_TIMEOUT_BITS = 16;
	localparam int BIT_CYCLES      = 40;
	localparam int FRAME_CYCLES    = 11 * BIT_CYCLES + (1 << `PS2_RING_BIT);
	localparam int CYCLE_LIMIT     = 5 * FRAME_CYCLES + 2 * (1 << TB_TIMEOUT_BITS) + 20000;

	logic                   sysclk;
	logic                   reset;
	ps2_host_pkg::bus_req_t bus_req;
	logic [7:0]             rdata;
	logic                   irq;
	logic                   clk_drive_low;
	logic                   dat_drive_low;
	logic                   dev_clk;
	logic                   dev_dat;
	logic                   ps2clk;
	logic                   ps2dat;
	int                     errors;
	int                     checks;
	int                     cycles;
	logic [7:0]             tx_byte;
	logic [7:0]             second_byte;
	logic [7:0]             rd_val;
	logic [10:0]            frame;

	// wired-and of the device and the host pull-downs.
	assign ps2clk = dev_clk & ~clk_drive_low;
	assign ps2dat = dev_dat & ~dat_drive_low;

	ps2_ctrl_top #(
		.TIMEOUT_BITS (TB_TIMEOUT_BITS)
	) dut_i (
		.sysclk        (sysclk),
		.reset         (reset),
		.bus_req       (bus_req),
		.rdata         (rdata),
		.irq           (irq),
		.ps2clk        (ps2clk),
		.ps2dat        (ps2dat),
		.clk_drive_low (clk_drive_low),
		.dat_drive_low (dat_drive_low)
	);

	initial begin
		sysclk = 1'b0;
		forever #10 sysclk = ~sysclk;
	end

	task automatic tick(input int n);
		repeat (n) @(posedge sysclk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic write_reg(input ps2_host_pkg::reg_addr_e addr, input logic [7:0] data);
		bus_req.wr    = 1'b1;
		bus_req.addr  = addr;
		bus_req.wdata = data;
		tick(1);
		bus_req.wr = 1'b0;
	endtask

	// rdata sampled mid cycle, well clear of the edge.
	task automatic read_reg(input ps2_host_pkg::reg_addr_e addr, output logic [7:0] data);
		bus_req.rd   = 1'b1;
		bus_req.addr = addr;
		#10;
		data = rdata;
		tick(1);
		bus_req.rd = 1'b0;
	endtask

	task automatic wait_status_bit(input int idx, input logic val);
		logic [7:0] s;
		read_reg(ps2_host_pkg::REG_STATUS, s);
		while (s[idx] !== val)
			read_reg(ps2_host_pkg::REG_STATUS, s);
	endtask

	// set when the byte holds an even number of ones.
	function automatic logic odd_parity(input logic [7:0] b);
		int ones;
		ones = 0;
		for (int i = 0; i < 8; i++)
			ones += b[i];
		return (ones % 2) == 0;
	endfunction

	// device to host, data moves in the middle of the high phase.
	task automatic device_send(input logic [7:0] b);
		logic [10:0] bits;
		bits = {1'b1, odd_parity(b), b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			dev_dat = bits[i];
			tick(BIT_CYCLES / 4);
			dev_clk = 1'b0;
			tick(BIT_CYCLES / 2);
			dev_clk = 1'b1;
			tick(BIT_CYCLES / 4);
		end
		dev_dat = 1'b1;
	endtask

	// host to device, each bit read just before a falling edge.
	task automatic device_receive(output logic [10:0] bits);
		while (!clk_drive_low)
			tick(1);
		while (clk_drive_low)
			tick(1);
		tick(BIT_CYCLES / 2);
		for (int i = 0; i < 11; i++) begin
			tick(BIT_CYCLES / 4);
			bits[i] = ps2dat;
			tick(BIT_CYCLES / 4);
			dev_clk = 1'b0;
			tick(BIT_CYCLES / 2);
			dev_clk = 1'b1;
		end
	endtask

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge sysclk);
			cycles++;
		end
		$display("cycle limit of %0d reached before the tests completed", CYCLE_LIMIT);
		$display("checks: %0d, value errors: %0d, assertion failures: %0d",
			checks, errors, dut_i.sva_i.fail_count);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		errors  = 0;
		checks  = 0;
		void'($urandom(32'h8213_1732));
		reset   = 1'b1;
		bus_req = '0;
		dev_clk = 1'b1;
		dev_dat = 1'b1;
		tick(4);
		reset = 1'b0;
		tick(1);

		// quiet after reset.
		check_value("irq", irq, 8'h00);
		check_value("clk_drive_low", clk_drive_low, 8'h00);
		check_value("dat_drive_low", dat_drive_low, 8'h00);
		read_reg(ps2_host_pkg::REG_STATUS, rd_val);
		check_value("status", rd_val, 8'h00);
		tick(10);

		// device to host with irq enabled.
		write_reg(ps2_host_pkg::REG_CTRL, 8'h80);
		read_reg(ps2_host_pkg::REG_CTRL, rd_val);
		check_value("ctrl", rd_val, 8'h80);
		tx_byte = 8'($urandom());
		device_send(tx_byte);
		wait_status_bit(0, 1'b1);
		check_value("irq", irq, 8'h01);
		read_reg(ps2_host_pkg::REG_DATA, rd_val);
		check_value("rx_byte", rd_val, tx_byte);
		read_reg(ps2_host_pkg::REG_STATUS, rd_val);
		check_value("rx_valid", rd_val[0], 8'h00);
		check_value("irq", irq, 8'h00);

		// host to device.
		tx_byte = 8'($urandom());
		write_reg(ps2_host_pkg::REG_DATA, tx_byte);
		// a second write while busy is dropped.
		write_reg(ps2_host_pkg::REG_DATA, ~tx_byte);
		device_receive(frame);
		check_value("start bit", frame[0], 8'h00);
		check_value("tx_byte", frame[8:1], tx_byte);
		check_value("parity bit", frame[9], odd_parity(tx_byte));
		check_value("stop bit", frame[10], 8'h01);
		wait_status_bit(3, 1'b0);
		read_reg(ps2_host_pkg::REG_STATUS, rd_val);
		check_value("timed_out", rd_val[2], 8'h00);

		// two frames without a read, irq off.
		write_reg(ps2_host_pkg::REG_CTRL, 8'h00);
		tx_byte     = 8'($urandom());
		second_byte = 8'($urandom());
		device_send(tx_byte);
		device_send(second_byte);
		wait_status_bit(1, 1'b1);
		check_value("irq", irq, 8'h00);
		read_reg(ps2_host_pkg::REG_DATA, rd_val);
		check_value("rx_byte", rd_val, second_byte);
		write_reg(ps2_host_pkg::REG_STATUS, 8'h02);
		read_reg(ps2_host_pkg::REG_STATUS, rd_val);
		check_value("overrun", rd_val[1], 8'h00);

		// send with the device silent.
		write_reg(ps2_host_pkg::REG_DATA, 8'($urandom()));
		wait_status_bit(3, 1'b0);
		read_reg(ps2_host_pkg::REG_STATUS, rd_val);
		check_value("timed_out", rd_val[2], 8'h01);
		write_reg(ps2_host_pkg::REG_STATUS, 8'h04);
		read_reg(ps2_host_pkg::REG_STATUS, rd_val);
		check_value("timed_out", rd_val[2], 8'h00);

		$display("checks: %0d, value errors: %0d, assertion failures: %0d",
			checks, errors, dut_i.sva_i.fail_count);
		if (errors != 0 || dut_i.sva_i.fail_count != 0)
			$display("Simulation finished: FAIL");
		else
			$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
